//--- kl10Pkg.sv
package kl10Pkg;

  localparam int wordW     = 36;
  localparam int halfW     = wordW / 2;  // Adder split point at bit 18
  localparam int cramAddrW = 8;
  localparam int cramDepth = 1 << cramAddrW;

  // AD function with A as AR and B as ARX
  typedef enum logic [3:0] {
    adfA,
    adfB,
    adfAPlusB,
    adfAMinusB,
    adfAPlus1,
    adfAnd,
    adfOr,
    adfXor,
    adfZero
  } adFunc_e;

  typedef enum logic [2:0] {
    arHold,
    arAd,
    arEbus,
    arArx,
    arClr
  } arSel_e;

  typedef enum logic [2:0] {
    arxHold,
    arxAd,
    arxAr,
    arxClr
  } arxSel_e;

  typedef enum logic [1:0] {
    mqHold,
    mqAd,
    mqShiftIn,  // AR bit 35 into MQ bit 0
    mqClr
  } mqSel_e;

  typedef enum logic [4:0] {
    dispNICOND,
    dispRETURN,
    dispMUL,
    dispNORM,
    dispDRAM_A_RD,
    dispDIV,
    dispEA_MOD
  } disp_e;

  typedef enum logic [4:0] {
    specNone,
    specINH_CRY18,
    specGEN_CRY18,
    specCALL,
    specHALT,
    specMQ_SHIFT,
    specAD_LONG
  } spec_e;

  // 30-bit microword that sits in EBUS bits 6..35 on a diag write
  typedef struct packed {
    adFunc_e              ad;
    arSel_e               arSel;
    arxSel_e              arxSel;
    mqSel_e               mqSel;
    disp_e                disp;
    spec_e                spec;
    logic [cramAddrW-1:0] j;
  } cramWord_t;

  localparam int cramWordW = $bits(cramWord_t);

  typedef struct packed {
    arSel_e  arSel;
    arxSel_e arxSel;
    mqSel_e  mqSel;
    adFunc_e adFunc;
    logic    adCarry36;
    logic    inhibitCarry18;
    logic    genCarry18;
    logic    mqShift;
  } ctlDecode_t;

  typedef struct packed {
    logic       adZero;
    logic       adNeg;
    logic [1:0] mqLow;  // MQ bits 34..35
  } edpStatus_t;

  // Read functions all have the top bit set
  typedef enum logic [2:0] {
    diagLOAD_CRA,
    diagWRITE_CRAM,
    diagSTART,
    diagSTOP,
    diagREAD_AR,
    diagREAD_ARX,
    diagREAD_MQ,
    diagREAD_CRA
  } diagFunc_e;

endpackage

//--- cram.sv
`timescale 1ns/100ps

// Control RAM with synchronous read addressed by the next CRA
module cram (
  input  logic                              eboxClk,
  input  logic [kl10Pkg::cramAddrW-1:0]     nextCra,
  input  logic                              wrEn,
  input  logic [kl10Pkg::cramAddrW-1:0]     wrAddr,
  input  kl10Pkg::cramWord_t                wrWord,
  output kl10Pkg::cramWord_t                word
);

  import kl10Pkg::*;

  cramWord_t mem [cramDepth];

  logic bypass;

  // Write to the word being fetched shows up right away
  assign bypass = wrEn && (wrAddr == nextCra);

  always_ff @(posedge eboxClk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrWord;
    end
  end

  always_ff @(posedge eboxClk) begin
    if (bypass) begin
      word <= wrWord;
    end else begin
      word <= mem[nextCra];
    end
  end

endmodule

//--- ctl.sv
`timescale 1ns/100ps

// CTL does microword decode, microaddress sequencing, run control and diag EBUS
module ctl (
  input  logic                            eboxClk,
  input  logic                            arstN,
  input  logic [0:kl10Pkg::wordW-1]       ebus,
  input  logic                            ebusDsStrobe,
  input  kl10Pkg::diagFunc_e              diagFunc,
  input  kl10Pkg::cramWord_t              word,
  input  kl10Pkg::edpStatus_t             status,
  input  logic [0:kl10Pkg::wordW-1]       ar,
  input  logic [0:kl10Pkg::wordW-1]       arx,
  input  logic [0:kl10Pkg::wordW-1]       mq,
  output kl10Pkg::ctlDecode_t             dec,
  output logic [kl10Pkg::cramAddrW-1:0]   nextCra,
  output logic                            wrEn,
  output logic [kl10Pkg::cramAddrW-1:0]   wrAddr,
  output kl10Pkg::cramWord_t              wrWord,
  output logic                            ctlDrivingEbus,
  output logic [0:kl10Pkg::wordW-1]       ctlEbus,
  output logic                            running
);

  import kl10Pkg::*;

  logic [cramAddrW-1:0] cra;
  logic [cramAddrW-1:0] loadCra;   // Last LOAD_CRA value
  logic [cramAddrW-1:0] retAddr;   // One-deep return register
  logic [cramAddrW-1:0] dispAddr;

  logic strobeLoad;
  logic strobeWrite;
  logic strobeStart;
  logic strobeStop;

  logic specInhCry18;
  logic specGenCry18;
  logic specCall;
  logic specHalt;
  logic specMqShift;

  // Load, write and start only while idle
  assign strobeLoad  = ebusDsStrobe && !running && (diagFunc == diagLOAD_CRA);
  assign strobeWrite = ebusDsStrobe && !running && (diagFunc == diagWRITE_CRAM);
  assign strobeStart = ebusDsStrobe && !running && (diagFunc == diagSTART);
  assign strobeStop  = ebusDsStrobe && (diagFunc == diagSTOP);

  assign wrEn   = strobeWrite;
  assign wrAddr = loadCra;
  assign wrWord = cramWord_t'(ebus[wordW-cramWordW:wordW-1]);

  always_comb begin
    specInhCry18 = 1'b0;
    specGenCry18 = 1'b0;
    specCall     = 1'b0;
    specHalt     = 1'b0;
    specMqShift  = 1'b0;
    case (word.spec)
      specINH_CRY18: specInhCry18 = 1'b1;
      specGEN_CRY18: specGenCry18 = 1'b1;
      specCALL:      specCall = 1'b1;
      specHALT:      specHalt = 1'b1;
      specMQ_SHIFT:  specMqShift = 1'b1;
      specAD_LONG:   ;  // Long AD not modeled here
      default:       ;
    endcase
  end

  always_comb begin
    dec.arSel          = running ? word.arSel : arHold;
    dec.arxSel         = running ? word.arxSel : arxHold;
    dec.mqSel          = running ? word.mqSel : mqHold;
    dec.adFunc         = word.ad;
    dec.adCarry36      = (word.ad == adfAMinusB) || (word.ad == adfAPlus1);
    dec.inhibitCarry18 = specInhCry18;
    dec.genCarry18     = specGenCry18;
    dec.mqShift        = specMqShift;
  end

  // Dispatch replaces the low bits of J with status bits
  always_comb begin
    dispAddr = word.j;
    case (word.disp)
      dispNICOND: dispAddr = word.j;
      dispRETURN: dispAddr = retAddr;
      dispMUL:    dispAddr = {word.j[cramAddrW-1:2], status.mqLow};
      dispNORM:   dispAddr = {word.j[cramAddrW-1:2], status.adZero, status.adNeg};
      default:    ;  // Others fall through to J
    endcase
  end

  always_comb begin
    if (running) begin
      nextCra = dispAddr;
    end else if (strobeStart) begin
      nextCra = loadCra;
    end else begin
      nextCra = cra;
    end
  end

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      cra     <= '0;
      loadCra <= '0;
      retAddr <= '0;
      running <= 1'b0;
    end else begin
      cra <= nextCra;
      if (strobeLoad) begin
        loadCra <= ebus[wordW-cramAddrW:wordW-1];
      end
      if (running && specCall) begin
        retAddr <= word.j + 1'b1;
      end
      if (running) begin
        running <= !(specHalt || strobeStop);  // HALT word still retires
      end else begin
        running <= strobeStart;
      end
    end
  end

  assign ctlDrivingEbus = ebusDsStrobe && diagFunc[2];

  always_comb begin
    ctlEbus = '0;
    if (ctlDrivingEbus) begin
      case (diagFunc)
        diagREAD_AR:  ctlEbus = ar;
        diagREAD_ARX: ctlEbus = arx;
        diagREAD_MQ:  ctlEbus = mq;
        diagREAD_CRA: ctlEbus[wordW-cramAddrW:wordW-1] = cra;
        default:      ;
      endcase
    end
  end

endmodule

//--- edp.sv
`timescale 1ns/100ps

// EDP holds AR, ARX, MQ and the 36-bit adder split at bit 18
module edp (
  input  logic                        eboxClk,
  input  logic                        arstN,
  input  kl10Pkg::ctlDecode_t         dec,
  input  logic [0:kl10Pkg::wordW-1]   ebus,
  output logic [0:kl10Pkg::wordW-1]   ar,
  output logic [0:kl10Pkg::wordW-1]   arx,
  output logic [0:kl10Pkg::wordW-1]   mq,
  output kl10Pkg::edpStatus_t         status
);

  import kl10Pkg::*;

  logic [0:wordW-1]     bOp;
  logic [0:wordW-1]     ad;
  logic [0:wordW-1]     sum;
  logic [halfW:wordW-1] rightSum;
  logic [0:halfW-1]     leftSum;
  logic                 cry18;     // Carry out of the right half
  logic                 cry18In;   // Carry into the left half

  // B operand inverted for subtract and zero for increment
  always_comb begin
    case (dec.adFunc)
      adfAMinusB: bOp = ~arx;
      adfAPlus1:  bOp = '0;
      default:    bOp = arx;
    endcase
  end

  assign {cry18, rightSum} = {1'b0, ar[halfW:wordW-1]} + {1'b0, bOp[halfW:wordW-1]}
                             + (halfW + 1)'(dec.adCarry36);

  assign cry18In = dec.genCarry18 || (cry18 && !dec.inhibitCarry18);

  assign leftSum = ar[0:halfW-1] + bOp[0:halfW-1] + halfW'(cry18In);
  assign sum     = {leftSum, rightSum};

  always_comb begin
    case (dec.adFunc)
      adfA:       ad = ar;
      adfB:       ad = arx;
      adfAPlusB,
      adfAMinusB,
      adfAPlus1:  ad = sum;
      adfAnd:     ad = ar & arx;
      adfOr:      ad = ar | arx;
      adfXor:     ad = ar ^ arx;
      default:    ad = '0;
    endcase
  end

  assign status.adZero = (ad == '0);
  assign status.adNeg  = ad[0];
  assign status.mqLow  = mq[wordW-2:wordW-1];

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      ar  <= '0;
      arx <= '0;
      mq  <= '0;
    end else begin
      case (dec.arSel)
        arAd:    ar <= ad;
        arEbus:  ar <= ebus;
        arArx:   ar <= arx;
        arClr:   ar <= '0;
        default: ;
      endcase

      case (dec.arxSel)
        arxAd:   arx <= ad;
        arxAr:   arx <= ar;
        arxClr:  arx <= '0;
        default: ;
      endcase

      case (dec.mqSel)
        mqAd:      mq <= ad;
        mqShiftIn: begin
          if (dec.mqShift) begin
            mq <= {ar[wordW-1], mq[0:wordW-2]};  // Right shift with AR35 entering bit 0
          end
        end
        mqClr:     mq <= '0;
        default:   ;
      endcase
    end
  end

endmodule

//--- eboxSlice.sv
`timescale 1ns/100ps

// EBOX slice top with CRAM, CTL and EDP on the diag EBUS
module eboxSlice (
  input  logic                        eboxClk,
  input  logic                        arstN,
  input  logic [0:kl10Pkg::wordW-1]   ebus,
  input  logic                        ebusDsStrobe,
  input  kl10Pkg::diagFunc_e          diagFunc,
  output logic                        ctlDrivingEbus,
  output logic [0:kl10Pkg::wordW-1]   ctlEbus,
  output logic                        running
);

  import kl10Pkg::*;

  cramWord_t            word;
  cramWord_t            wrWord;
  ctlDecode_t           dec;
  edpStatus_t           status;
  logic [cramAddrW-1:0] nextCra;
  logic [cramAddrW-1:0] wrAddr;
  logic                 wrEn;
  logic [0:wordW-1]     ar;
  logic [0:wordW-1]     arx;
  logic [0:wordW-1]     mq;

  cram cram0 (
    .eboxClk (eboxClk),
    .nextCra (nextCra),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrWord  (wrWord),
    .word    (word)
  );

  ctl ctl0 (
    .eboxClk        (eboxClk),
    .arstN          (arstN),
    .ebus           (ebus),
    .ebusDsStrobe   (ebusDsStrobe),
    .diagFunc       (diagFunc),
    .word           (word),
    .status         (status),
    .ar             (ar),
    .arx            (arx),
    .mq             (mq),
    .dec            (dec),
    .nextCra        (nextCra),
    .wrEn           (wrEn),
    .wrAddr         (wrAddr),
    .wrWord         (wrWord),
    .ctlDrivingEbus (ctlDrivingEbus),
    .ctlEbus        (ctlEbus),
    .running        (running)
  );

  edp edp0 (
    .eboxClk (eboxClk),
    .arstN   (arstN),
    .dec     (dec),
    .ebus    (ebus),
    .ar      (ar),
    .arx     (arx),
    .mq      (mq),
    .status  (status)
  );

endmodule

//--- tbChecker.sv
`timescale 1ns/100ps

// Watches the diag EBUS readback and compares it with the expected word
module tbChecker (
  input  logic                        eboxClk,
  input  logic                        ebusDsStrobe,
  input  kl10Pkg::diagFunc_e          diagFunc,
  input  logic                        ctlDrivingEbus,
  input  logic [0:kl10Pkg::wordW-1]   ctlEbus,
  input  logic                        running,
  input  logic [0:kl10Pkg::wordW-1]   expWord,
  input  logic                        idleCheck,
  output int                          errors,
  output int                          checks
);

  import kl10Pkg::*;

  initial begin
    errors = 0;
    checks = 0;
  end

  // Sample mid-cycle while the host inputs are stable
  always @(negedge eboxClk) begin
    if (ebusDsStrobe && (diagFunc inside {diagREAD_AR, diagREAD_ARX,
                                          diagREAD_MQ, diagREAD_CRA})) begin
      checks = checks + 1;
      if (ctlDrivingEbus !== 1'b1) begin
        errors = errors + 1;
        $display("At %0t ns CTL is not driving EBUS during the %s read",
                 $time, diagFunc.name());
      end else if (ctlEbus !== expWord) begin
        errors = errors + 1;
        $display("FAILED %0t ns: %s expected %09h, got %09h",
                 $time, diagFunc.name(), expWord, ctlEbus);
      end
    end

    if (idleCheck) begin
      checks = checks + 1;
      if (running !== 1'b0) begin
        errors = errors + 1;
        $display("At %0t ns the EBOX is still running after STOP", $time);
      end
    end
  end

endmodule

//--- tbEbox.sv
`timescale 1ns/100ps

module tbEbox;

  import kl10Pkg::*;

  localparam int maxCmds  = 256;
  localparam int runLimit = 64;  // Cycles allowed for one run

  logic             eboxClk;
  logic             arstN;
  logic [0:wordW-1] ebus;
  logic             ebusDsStrobe;
  diagFunc_e        diagFunc;
  logic             ctlDrivingEbus;
  logic [0:wordW-1] ctlEbus;
  logic             running;
  logic [0:wordW-1] expWord;
  logic             idleCheck;
  int               errors;
  int               checks;
  int               stimErrors;
  int               limitCycles;

  logic [7:0]       cmdQ [maxCmds];
  int               funcQ [maxCmds];
  logic [0:wordW-1] wordQ [maxCmds];
  logic [0:wordW-1] argQ [maxCmds];
  int               numCmds;

  eboxSlice dut0 (
    .eboxClk        (eboxClk),
    .arstN          (arstN),
    .ebus           (ebus),
    .ebusDsStrobe   (ebusDsStrobe),
    .diagFunc       (diagFunc),
    .ctlDrivingEbus (ctlDrivingEbus),
    .ctlEbus        (ctlEbus),
    .running        (running)
  );

  tbChecker chk0 (
    .eboxClk        (eboxClk),
    .ebusDsStrobe   (ebusDsStrobe),
    .diagFunc       (diagFunc),
    .ctlDrivingEbus (ctlDrivingEbus),
    .ctlEbus        (ctlEbus),
    .running        (running),
    .expWord        (expWord),
    .idleCheck      (idleCheck),
    .errors         (errors),
    .checks         (checks)
  );

  always #5 eboxClk = ~eboxClk;

  task automatic readStim();
    int         fd;
    int         code;
    string      line;
    logic [7:0] c;
    int         f;
    logic [0:wordW-1] w;
    logic [0:wordW-1] a;
    fd = $fopen("eboxStim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open eboxStim.txt");
      stimErrors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 1 && line[0] != "#") begin
          code = $sscanf(line, "%c %h %h %h", c, f, w, a);
          if (code == 4 && numCmds < maxCmds) begin
            cmdQ[numCmds]  = c;
            funcQ[numCmds] = f;
            wordQ[numCmds] = w;
            argQ[numCmds]  = a;
            numCmds++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One host strobe driven 1 ns after the edge with ebus left in place
  task automatic pulseStrobe(input diagFunc_e f, input logic [0:wordW-1] w);
    @(posedge eboxClk);
    #1;
    diagFunc     = f;
    ebus         = w;
    ebusDsStrobe = 1'b1;
    @(posedge eboxClk);
    #1;
    ebusDsStrobe = 1'b0;
  endtask

  task automatic pulseIdleCheck();
    @(posedge eboxClk);
    #1;
    idleCheck = 1'b1;
    @(posedge eboxClk);
    #1;
    idleCheck = 1'b0;
  endtask

  // Start at addr with ebus held at operand and wait for HALT
  task automatic runFrom(input logic [0:wordW-1] addr, input logic [0:wordW-1] operand);
    int n;
    n = 0;
    pulseStrobe(diagLOAD_CRA, addr);
    pulseStrobe(diagSTART, operand);
    while (running && n < runLimit) begin
      @(posedge eboxClk);
      #1;
      n++;
    end
  endtask

  initial begin
    int total;
    eboxClk      = 1'b0;
    arstN        = 1'b0;
    ebus         = '0;
    ebusDsStrobe = 1'b0;
    diagFunc     = diagLOAD_CRA;
    expWord      = '0;
    idleCheck    = 1'b0;
    numCmds      = 0;
    stimErrors   = 0;
    limitCycles  = 0;
    total        = 0;

    readStim();
    for (int i = 0; i < numCmds; i++) begin
      case (cmdQ[i])
        "P":     total += 4;
        "G":     total += 4 + runLimit;
        default: total += 2;
      endcase
    end
    limitCycles = total * 2 + 100;

    repeat (8) @(posedge eboxClk);
    #1;
    arstN = 1'b1;

    for (int i = 0; i < numCmds; i++) begin
      case (cmdQ[i])
        "P": begin
          pulseStrobe(diagLOAD_CRA, argQ[i]);
          pulseStrobe(diagWRITE_CRAM, wordQ[i]);
        end
        "G": runFrom(argQ[i], wordQ[i]);
        "S": pulseStrobe(diagFunc_e'(funcQ[i]), wordQ[i]);
        "R": begin
          expWord = argQ[i];
          pulseStrobe(diagFunc_e'(funcQ[i]), wordQ[i]);
        end
        "Q": pulseIdleCheck();
        default: begin
          stimErrors++;
          $display("Unknown command on stim line %0d", i + 1);
        end
      endcase
    end

    @(posedge eboxClk);
    $display("Checks: %0d, errors: %0d", checks, errors + stimErrors);
    if (errors == 0 && stimErrors == 0 && checks > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limitCycles > 0);
    #(limitCycles * 10);
    $display("Run timed out after %0d cycles", limitCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- eboxStim.txt
# cmd func ebus arg, all hex. P writes microword ebus at address arg,
# G starts at arg with ebus held, S strobes func, R reads func expecting arg, Q checks idle
R 4 0 0
R 5 0 0
R 6 0 0
R 7 0 0
P 0 1200402 01
P 0 8040400 02
P 0 C040400 03
P 0 14040400 04
P 0 18040400 05
P 0 1C040400 06
P 0 8040208 07
P 0 400 08
P 0 8040108 09
G 0 0F0 01
G 0 1030 01
R 4 0 1030
R 5 0 0F0
G 0 0 02
R 6 0 1120
G 0 0 03
R 6 0 F40
G 0 0 04
R 6 0 30
G 0 0 05
R 6 0 10F0
G 0 0 06
R 6 0 10C0
G 0 0 07
R 6 0 41120
G 0 1 01
G 0 7FFFF 01
G 0 0 09
R 6 0 40000
P 0 6020 10
P 0 20006020 11
P 0 4800400 21
P 0 10800400 22
G 0 800000000 01
G 0 0 10
R 4 0 7FFFF
G 0 0 11
R 4 0 80000
P 0 40030 31
P 0 4040 30
P 0 4800400 43
P 0 10800400 42
G 0 3 01
G 0 0 31
R 4 0 80000
G 0 2 01
G 0 0 31
R 4 0 3
R 6 0 2
P 0 10800360 50
P 0 10800070 60
P 0 10802000 70
P 0 10800462 61
G 0 0 50
R 4 0 7
R 7 0 62
P 0 1000080 80
G 0 123456789 80
S 3 123456789 0
Q 0 0 0
R 4 0 123456789
R 7 0 80
P 0 C0090 8F
P 0 1A80591 90
P 0 1A80592 91
P 0 1A80593 92
P 0 400 93
G 0 0 01
G 0 1 01
G 0 0 8F
R 6 0 A00000000
R 4 0 0
R 5 0 1

//--- compile.f
kl10Pkg.sv
cram.sv
ctl.sv
edp.sv
eboxSlice.sv
tbChecker.sv
tbEbox.sv

//--- Bender.yml
package:
  name: kl10_ebox_slice

sources:
  - kl10Pkg.sv
  - cram.sv
  - ctl.sv
  - edp.sv
  - eboxSlice.sv
  - target: test
    files:
      - tbChecker.sv
      - tbEbox.sv
